//--- count_pkg.sv
`default_nettype none

package count_pkg;

  ///////////////////////////////
  // Sizes
  ///////////////////////////////
  localparam int DIV_WIDTH = 32; // Free divider counter
  localparam int SEL_WIDTH = 5;  // Picks one of 32 divider bits
  localparam int SCAN_BITS = 10; // Digit swap every 1024 cycles

  ///////////////////////////////
  // Bundles between blocks
  ///////////////////////////////

  // Two-digit decimal value, tens in the upper nibble
  typedef struct packed {
    logic [3:0] tens;
    logic [3:0] units;
  } bcd_count_t;

  // Display drive, everything active low
  typedef struct packed {
    logic [6:0] seg; // a in bit 0 up to g in bit 6
    logic [1:0] an;  // Bit 0 units, bit 1 tens
  } seg_drive_t;

  // Direction and per-digit enables
  typedef struct packed {
    logic up;       // 1 counts up
    logic units_en; // Step the units digit
    logic tens_en;  // Step the tens digit
  } step_t;

endpackage

`default_nettype wire

//--- rate_tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

// Divider bit picked by sel, its rising edge becomes a one-cycle tick
module rate_tick_gen (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic [count_pkg::SEL_WIDTH-1:0] sel,  // Registered in count_ctrl
  output logic                                tick
);

  import count_pkg::*;

  logic [DIV_WIDTH-1:0] div_cnt; // Free running
  logic                 sel_bit;
  logic                 sel_bit_q; // Last cycle's value of the picked bit

  // Plain binary counter, wraps on its own
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign sel_bit = div_cnt[sel]; // Bit k toggles every 2^k cycles

  ///////////////////////////////
  // Edge detect
  ///////////////////////////////

  // Tick lands one cycle after the bit goes 0 to 1
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_bit_q <= 1'b0;
      tick      <= 1'b0;
    end else begin
      sel_bit_q <= sel_bit;
      tick      <= sel_bit & ~sel_bit_q; // Rise only
    end
  end

  // A select change can fake an edge
  // That first interval is not a clean period anyway

endmodule

`default_nettype wire

//--- count_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// Input sync, rate select register and step/carry sequencing
module count_ctrl (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            tick,       // From rate_tick_gen
  input  wire logic                            dir_btn,    // Pressed = count down
  input  wire logic [count_pkg::SEL_WIDTH-1:0] rate_sel,   // Raw switches
  input  wire logic                            units_wrap, // Units about to wrap
  output logic      [count_pkg::SEL_WIDTH-1:0] sel_q,
  output count_pkg::step_t                     step
);

  logic dir_meta;  // First sync stage
  logic dir_sync;  // Second sync stage

  ///////////////////////////////
  // Input registers
  ///////////////////////////////

  // Button is asynchronous to clk
  always_ff @(posedge clk) begin
    if (rst) begin
      dir_meta <= 1'b0; // Released, so up after reset
      dir_sync <= 1'b0;
    end else begin
      dir_meta <= dir_btn;
      dir_sync <= dir_meta;
    end
  end

  // Switches held for one register stage
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= '0;
    end else begin
      sel_q <= rate_sel;
    end
  end

  ///////////////////////////////
  // Step and carry
  ///////////////////////////////

  // Tens carry formed in the same cycle as the units step
  // so both digits move on one edge
  always_comb begin
    step.up       = ~dir_sync;             // Released button counts up
    step.units_en = tick;                  // Units step on every tick
    step.tens_en  = tick & units_wrap;     // Carry or borrow
  end

endmodule

`default_nettype wire

//--- bcd_digit.sv
`timescale 1ns/100ps
`default_nettype none

// One decimal digit, up/down modulo ten
module bcd_digit (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       en,    // Step this cycle
  input  wire logic       up,    // 1 up, 0 down
  output logic      [3:0] digit,
  output logic            wrap   // Enabled step crosses 9/0
);

  logic at_top;    // Digit is 9
  logic at_bottom; // Digit is 0

  assign at_top    = (digit == 4'd9);
  assign at_bottom = (digit == 4'd0);

  // Boundary for the current direction, only when stepping
  assign wrap = en & (up ? at_top : at_bottom);

  ///////////////////////////////
  // Digit register
  ///////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      digit <= 4'd0;
    end else if (digit > 4'd9) begin
      digit <= 4'd0; // Illegal code, back to a known value
    end else if (en) begin
      if (up) begin
        // 9 rolls over to 0
        digit <= at_top ? 4'd0 : digit + 4'd1;
      end else begin
        // 0 rolls under to 9
        digit <= at_bottom ? 4'd9 : digit - 4'd1;
      end
    end
  end

  // Holds its value when en is low

endmodule

`default_nettype wire

//--- seg7_scan.sv
`timescale 1ns/100ps
`default_nettype none

// Two-digit scanner with BCD to seven-segment decode
module seg7_scan (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire count_pkg::bcd_count_t count,
  output count_pkg::seg_drive_t      drive
);

  import count_pkg::*;

  logic [SCAN_BITS:0]   scan_cnt;  // Low bits time one digit, top bit picks it
  logic                 show_tens; // Top scan bit
  logic [3:0]           cur_digit;

  ///////////////////////////////
  // Scan counter
  ///////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      scan_cnt <= '0; // Units shown first
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  assign show_tens = scan_cnt[SCAN_BITS]; // Flips every 2^SCAN_BITS cycles

  // Digit and anode pick
  always_comb begin
    if (show_tens) begin
      cur_digit = count.tens;
      drive.an  = 2'b01; // Tens anode low
    end else begin
      cur_digit = count.units;
      drive.an  = 2'b10; // Units anode low
    end
  end

  ///////////////////////////////
  // Segment decode
  ///////////////////////////////

  // Patterns are gfedcba, 0 lights a segment
  always_comb begin
    case (cur_digit)
      4'd0:    drive.seg = 7'b100_0000;
      4'd1:    drive.seg = 7'b111_1001; // b c
      4'd2:    drive.seg = 7'b010_0100;
      4'd3:    drive.seg = 7'b011_0000;
      4'd4:    drive.seg = 7'b001_1001;
      4'd5:    drive.seg = 7'b001_0010;
      4'd6:    drive.seg = 7'b000_0010;
      4'd7:    drive.seg = 7'b111_1000; // a b c
      4'd8:    drive.seg = 7'b000_0000; // All on
      4'd9:    drive.seg = 7'b001_0000;
      default: drive.seg = 7'b111_1111; // Blank on non-BCD
    endcase
  end

endmodule

`default_nettype wire

//--- counter_top.sv
`timescale 1ns/100ps
`default_nettype none

// Two-digit up/down counter with rate select and scanned display
module counter_top (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            dir_btn,  // Hold to count down
  input  wire logic [count_pkg::SEL_WIDTH-1:0] rate_sel, // Step every 2^(sel+1)
  output logic      [6:0]                      seg,
  output logic      [7:0]                      an,
  output logic      [12:0]                     led
);

  import count_pkg::*;

  logic [SEL_WIDTH-1:0] sel_q;       // Registered switches
  logic                 tick;
  logic                 units_wrap;
  logic [3:0]           units_digit;
  logic [3:0]           tens_digit;
  step_t                step;
  bcd_count_t           count;
  seg_drive_t           drive;

  ///////////////////////////////
  // Rate and control
  ///////////////////////////////
  rate_tick_gen i_tick (
    .clk  (clk),
    .rst  (rst),
    .sel  (sel_q),
    .tick (tick)
  );

  count_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .dir_btn    (dir_btn),
    .rate_sel   (rate_sel),
    .units_wrap (units_wrap),
    .sel_q      (sel_q),
    .step       (step)
  );

  ///////////////////////////////
  // Digits
  ///////////////////////////////
  bcd_digit i_units (
    .clk   (clk),
    .rst   (rst),
    .en    (step.units_en),
    .up    (step.up),
    .digit (units_digit),
    .wrap  (units_wrap)   // Feeds the tens carry
  );

  // Last digit, its wrap goes nowhere
  bcd_digit i_tens (
    .clk   (clk),
    .rst   (rst),
    .en    (step.tens_en),
    .up    (step.up),
    .digit (tens_digit),
    .wrap  ()
  );

  assign count = '{tens: tens_digit, units: units_digit};

  seg7_scan i_scan (
    .clk   (clk),
    .rst   (rst),
    .count (count),
    .drive (drive)
  );

  // Board outputs
  assign seg = drive.seg;
  assign an  = {6'b11_1111, drive.an}; // Only two digits fitted
  assign led = {count, sel_q};         // Tens, units, rate

endmodule

`default_nettype wire

//--- counter_props.sv
`timescale 1ns/100ps
`default_nettype none

// Structural properties of counter_top
module counter_props (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic       tick,
  input wire logic [7:0] an,
  input wire logic [3:0] units,
  input wire logic [3:0] tens
);

  // Edge detect gives single-cycle pulses
  no_double_tick: assert property (@(posedge clk) disable iff (rst) tick |=> !tick)
    else $error("tick high on two consecutive cycles");

  // Unused anodes stay off
  upper_an_off: assert property (@(posedge clk) disable iff (rst) an[7:2] == 6'b11_1111)
    else $error("upper anodes not all high");

  one_anode_low: assert property (@(posedge clk) disable iff (rst) $onehot(~an[1:0]))
    else $error("not exactly one digit anode low");

  digits_bcd: assert property (@(posedge clk) disable iff (rst) units <= 4'd9 && tens <= 4'd9)
    else $error("digit above 9");

endmodule

bind counter_top counter_props i_props (
  .clk   (clk),
  .rst   (rst),
  .tick  (tick),
  .an    (an),
  .units (units_digit),
  .tens  (tens_digit)
);

`default_nettype wire

//--- tb_counter_top.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for counter_top with random rate and direction runs
module tb_counter_top;

  import count_pkg::*;

  localparam int NUM_RUNS  = 12;  // Rate select runs
  localparam int MIN_RUN   = 300;
  localparam int MAX_RUN   = 900;
  localparam int RST_CYC   = 10;
  localparam int SCAN_HOLD = 1 << SCAN_BITS; // Each digit shown for 1024 cycles
  localparam int TIMEOUT_CYCLES = RST_CYC + NUM_RUNS * MAX_RUN + 200;

  logic                 clk;
  logic                 rst;
  logic                 dir_btn;
  logic [SEL_WIDTH-1:0] rate_sel;
  logic [6:0]           seg;
  logic [7:0]           an;
  logic [12:0]          led;

  integer      seed;
  logic [31:0] rnd;
  int          cyc;          // Cycles since reset release
  int          tmo_cyc;      // Free cycle count for the timeout
  int          model_cnt;    // Reference count 0 to 99
  int          last_chg;     // Cycle of the last count change
  int          sel_chg;      // Cycle rate_sel was last driven
  int          dir_left;     // Cycles left in the current direction run
  logic        d1, d2, d3;   // dir_btn history, d3 lines up with the step
  logic [1:0]  prev_an;
  int          hold;         // Cycles the current anode has been active
  bit          first_swap;
  int          err_count, err_rate, err_disp, err_scan;
  int          rate_checks;

  counter_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .dir_btn  (dir_btn),
    .rate_sel (rate_sel),
    .seg      (seg),
    .an       (an),
    .led      (led)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // Lit segments, gfedcba, 1 means on
  function automatic logic [6:0] lit_segments(input logic [3:0] d);
    case (d)
      4'd0:    return 7'b011_1111;
      4'd1:    return 7'b000_0110;
      4'd2:    return 7'b101_1011;
      4'd3:    return 7'b100_1111;
      4'd4:    return 7'b110_0110;
      4'd5:    return 7'b110_1101;
      4'd6:    return 7'b111_1101;
      4'd7:    return 7'b000_0111;
      4'd8:    return 7'b111_1111;
      4'd9:    return 7'b110_1111;
      default: return 7'b000_0000;
    endcase
  endfunction

  ///////////////////////////////
  // Per-cycle checks
  ///////////////////////////////
  task check_cycle();
    int         cur;
    int         expv;
    logic [6:0] exp_seg;
    cur = led[12:9] * 10 + led[8:5];
    if (led[12:9] > 9 || led[8:5] > 9) begin
      $display("Digit outside 0..9 at %0t: led = %h", $time, led);
      err_count++;
    end
    if (cur != model_cnt) begin
      expv = d3 ? (model_cnt + 99) % 100 : (model_cnt + 1) % 100; // Pressed counts down
      if (cur != expv) begin
        $display("MISMATCH at %0t: count got %0d expected %0d", $time, cur, expv);
        err_count++;
      end
      // Skip intervals touched by a select change
      if (led[4:0] == rate_sel && last_chg > sel_chg + 3) begin
        rate_checks++;
        if (cyc - last_chg != (1 << (rate_sel + 1))) begin
          $display("MISMATCH at %0t: step interval got %0d expected %0d",
                   $time, cyc - last_chg, 1 << (rate_sel + 1));
          err_rate++;
        end
      end
      last_chg  = cyc;
      model_cnt = cur; // Resync after any error
    end
    // Display follows whichever anode is low
    if (an[1:0] == 2'b10) begin
      exp_seg = ~lit_segments(led[8:5]);
    end else if (an[1:0] == 2'b01) begin
      exp_seg = ~lit_segments(led[12:9]);
    end else begin
      $display("Not exactly one digit anode low at %0t: an = %b", $time, an);
      err_disp++;
      exp_seg = seg;
    end
    if (seg !== exp_seg) begin
      $display("MISMATCH at %0t: seg got %b expected %b", $time, seg, exp_seg);
      err_disp++;
    end
    if (an[1:0] != prev_an) begin
      if (!first_swap && hold != SCAN_HOLD) begin
        $display("MISMATCH at %0t: anode hold got %0d expected %0d", $time, hold, SCAN_HOLD);
        err_scan++;
      end
      first_swap = 1'b0; // First segment starts mid-count
      hold       = 1;
      prev_an    = an[1:0];
    end else begin
      hold++;
    end
  endtask

  // Direction held for long random runs
  task drive_dir();
    d3 = d2;
    d2 = d1;
    if (dir_left == 0) begin
      rnd      = $random(seed);
      dir_btn  = rnd[0];
      rnd      = $random(seed);
      dir_left = 100 + rnd % 300;
    end else begin
      dir_left--;
    end
    d1 = dir_btn;
  endtask

  ///////////////////////////////
  // Main sequence
  ///////////////////////////////
  initial begin
    int run_len;
    int next_sel;
    seed     = 32'hd780_f4c6;
    rst      = 1'b1;
    dir_btn  = 1'b0;
    rnd      = $random(seed);
    rate_sel = rnd % 5;
    {d1, d2, d3} = 3'b000;
    {err_count, err_rate, err_disp, err_scan, rate_checks} = '0;
    dir_left = 200;
    repeat (RST_CYC) @(posedge clk);
    #2 rst = 1'b0;
    @(posedge clk);
    #1;
    // Reset state
    if (led[12:5] != 8'h00) begin
      $display("MISMATCH at %0t: led count got %h expected 00", $time, led[12:5]);
      err_count++;
    end
    if (led[4:0] != rate_sel) begin
      $display("MISMATCH at %0t: led rate got %0d expected %0d", $time, led[4:0], rate_sel);
      err_count++;
    end
    if (an[1:0] != 2'b10 || seg != ~lit_segments(4'd0)) begin
      $display("Display does not show units digit 0 after reset at %0t", $time);
      err_disp++;
    end
    cyc        = 0;
    model_cnt  = 0;
    last_chg   = 0;
    sel_chg    = 0;
    prev_an    = an[1:0];
    hold       = 1;
    first_swap = 1'b1;
    for (int run = 0; run < NUM_RUNS; run++) begin
      rnd      = $random(seed);
      run_len  = MIN_RUN + rnd % (MAX_RUN - MIN_RUN + 1);
      rnd      = $random(seed);
      next_sel = rnd % 5;
      for (int i = 0; i < run_len; i++) begin
        @(posedge clk);
        cyc++;
        #1 check_cycle();
        #1;
        if (i == 0) begin
          rate_sel = next_sel;
          sel_chg  = cyc;
        end
        drive_dir();
      end
    end
    if (rate_checks == 0) begin
      $display("No step interval was ever checked");
      err_rate++;
    end
    $display("Error counts: count %0d, rate %0d, display %0d, scan %0d",
             err_count, err_rate, err_disp, err_scan);
    if (err_count + err_rate + err_disp + err_scan == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Run cannot outlast all stimulus runs
  initial tmo_cyc = 0;
  always @(posedge clk) begin
    tmo_cyc++;
    if (tmo_cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, stimulus did not finish", tmo_cyc);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- all.f
count_pkg.sv
rate_tick_gen.sv
count_ctrl.sv
bcd_digit.sv
seg7_scan.sv
counter_top.sv
counter_props.sv
tb_counter_top.sv

//--- Bender.yml
package:
  name: counter_top

sources:
  - count_pkg.sv
  - rate_tick_gen.sv
  - count_ctrl.sv
  - bcd_digit.sv
  - seg7_scan.sv
  - counter_top.sv
  - target: test
    files:
      - counter_props.sv
      - tb_counter_top.sv
